// File: Makefile
# miniUncore simulation with Verilator

TOP = uncoreTb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wall -f miniUncore.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/clkGen.sv
// testbench clock and reset
// period 40, reset held low for the first 3 cycles

module clkGen (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;              // release away from the rising edge
  end

endmodule

// File: dv/uncoreTb.sv
// miniUncore testbench
// credit-aware bus master with LCG data; checking sits in the bound asserts

`include "uncore_defs.svh"

module uncoreTb;

  logic            clk, rstN;
  logic            reqValid, reqWrite;
  uncorePkg::addrT reqAddr;
  uncorePkg::dataT reqWdata, gpioIn;
  logic            rspValid, rspErr, creditReturn;
  uncorePkg::dataT rspData, gpioOut, gpioEn;
  logic            timerInt, swInt, gpioInt;
  int              credits;
  uncorePkg::dataT lastRsp;
  logic [31:0]     lcgState;

  clkGen clkGen (.clk, .rstN);

  uncoreTop DUT (
    .clk, .rstN,
    .reqValid, .reqWrite, .reqAddr, .reqWdata,
    .rspValid, .rspData, .rspErr, .creditReturn,
    .timerInt, .swInt, .gpioInt,
    .gpioIn, .gpioOut, .gpioEn
  );

  bind uncoreTop uncoreAssert checks (
    .clk, .rstN, .reqValid, .reqWrite, .reqAddr, .reqWdata,
    .rspValid, .rspData, .rspErr, .creditReturn,
    .timerInt, .swInt, .gpioInt, .gpioIn, .gpioOut, .gpioEn
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic uncorePkg::dataT lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic timeoutFail(input string what);
    $display("timeout while waiting for %s", what);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  // credits come back with each response
  always @(posedge clk) begin
    if (rstN && creditReturn) begin
      credits = credits + 1;
      lastRsp = rspData;
    end
  end

  // stop at the first assertion failure
  always @(posedge clk) begin
    if (DUT.checks.errCnt != 0) begin
      $display("ERRORS FOUND");
      $fatal(1, "assertion failed");
    end
  end

  // called on a falling edge, returns on a falling edge
  task automatic sendReq(input logic write, input uncorePkg::addrT addr,
                         input uncorePkg::dataT wdata);
    int waited;
    waited = 0;
    while (credits == 0) begin
      @(negedge clk);
      waited++;
      if (waited > 50) timeoutFail("a request credit");
    end
    reqValid = 1'b1;
    reqWrite = write;
    reqAddr  = addr;
    reqWdata = wdata;
    credits  = credits - 1;
    @(negedge clk);
    reqValid = 1'b0;
  endtask

  task automatic waitIdle();
    int waited;
    waited = 0;
    while (credits != `UC_CREDITS) begin
      @(negedge clk);
      waited++;
      if (waited > 100) timeoutFail("all responses");
    end
  endtask

  task automatic writeReg(input uncorePkg::addrT addr, input uncorePkg::dataT data);
    sendReq(1'b1, addr, data);
    waitIdle();
  endtask

  task automatic readReg(input uncorePkg::addrT addr, output uncorePkg::dataT data);
    sendReq(1'b0, addr, '0);
    waitIdle();
    data = lastRsp;
  endtask

  task automatic waitTimer(input int limit);
    int waited;
    waited = 0;
    while (!timerInt) begin
      @(negedge clk);
      waited++;
      if (waited > limit) timeoutFail("timerInt");
    end
  endtask

  task automatic waitGpioInt(input int limit);
    int waited;
    waited = 0;
    while (!gpioInt) begin
      @(negedge clk);
      waited++;
      if (waited > limit) timeoutFail("gpioInt");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int              i, waited;
    uncorePkg::dataT rd, mt;
    uncorePkg::addrT regAddr [4];
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr  = '0;
    reqWdata = '0;
    gpioIn   = '0;
    credits  = `UC_CREDITS;
    lcgState = 32'h0577_4a50;
    regAddr  = '{8'h41, 8'h42, 8'h43, 8'h04};  // out, en, riseIe, msip
    waited   = 0;
    while (rstN !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > 10) timeoutFail("reset release");
    end
    @(negedge clk);

    // write and read back
    for (i = 0; i < 8; i++) begin
      writeReg(regAddr[i % 4], lcgNext());
      readReg(regAddr[i % 4], rd);
    end

    // burst on all four credits, then more than the credits allow
    for (i = 0; i < 4; i++) sendReq(1'b1, regAddr[i], lcgNext());
    for (i = 0; i < 6; i++) sendReq(1'b0, regAddr[i % 4], '0);
    waitIdle();

    // unmapped blocks 2 and 3
    for (i = 0; i < 6; i++) begin
      if (i % 2 == 0) writeReg({2'(2 + i % 2), 6'(lcgNext())}, lcgNext());
      else readReg({2'(2 + i % 2), 6'(lcgNext())}, rd);
    end

    // timer, compare 40 ticks ahead of the read value
    writeReg(8'h03, '0);
    readReg(8'h00, mt);
    writeReg(8'h02, mt + 32'd40);
    waitTimer(60);
    readReg(8'h00, rd);
    readReg(8'h00, rd);

    // gpio rise interrupt on bit 5, bit 2 left disabled
    writeReg(8'h43, 32'h20);
    writeReg(8'h44, '1);
    gpioIn = 32'h4;
    repeat (8) @(negedge clk);
    gpioIn = 32'h24;
    waitGpioInt(4);
    writeReg(8'h44, 32'h20);
    readReg(8'h40, rd);
    repeat (4) @(negedge clk);

    if (DUT.checks.errCnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("ERRORS FOUND");
      $fatal(1, "checks failed");
    end
  end

endmodule

// File: dv/uncore_assert.sv
// miniUncore checker, bound to the top level
// shadow of the written registers plus an in-order request model

`include "uncore_defs.svh"

module uncoreAssert (
  input logic            clk,
  input logic            rstN,
  input logic            reqValid,
  input logic            reqWrite,
  input uncorePkg::addrT reqAddr,
  input uncorePkg::dataT reqWdata,
  input logic            rspValid,
  input uncorePkg::dataT rspData,
  input logic            rspErr,
  input logic            creditReturn,
  input logic            timerInt,
  input logic            swInt,
  input logic            gpioInt,
  input uncorePkg::dataT gpioIn,
  input uncorePkg::dataT gpioOut,
  input uncorePkg::dataT gpioEn
);

  int               errCnt = 0;     // read by the testbench
  logic             mWrite [8];     // request model, deeper than the queue
  uncorePkg::addrT  mAddr  [8];
  uncorePkg::dataT  mWdata [8];
  logic [2:0]       wp, rp;
  int               outstanding;
  uncorePkg::dataT  shOut, shEn, shIe, shMsip;
  uncorePkg::mtimeT shCmp;
  uncorePkg::dataT  armed, inPrev, rise, clr;
  uncorePkg::dataT  lastMt;
  logic             haveMt;
  int               riseCnt, timerCnt;
  logic             hWrite;
  uncorePkg::addrT  hAddr;
  uncorePkg::dataT  hWdata;
  logic [1:0]       hSel;
  uncorePkg::offT   hOff;
  uncorePkg::dataT  expRd;
  logic             expKnown;
  logic             hClint, hGpio;

  ////////////////////////////////////////////////////////////
  // head of the model queue and expected read data
  ////////////////////////////////////////////////////////////

  assign hWrite = mWrite[rp];
  assign hAddr  = mAddr[rp];
  assign hWdata = mWdata[rp];
  assign hSel   = hAddr[7:6];
  assign hOff   = hAddr[`UC_OFF_W-1:0];
  assign hClint = rspValid && hSel == 2'(`UC_SEL_CLINT);
  assign hGpio  = rspValid && hSel == 2'(`UC_SEL_GPIO);
  assign rise   = gpioIn & ~inPrev & shIe;
  assign clr    = (hGpio && hWrite && hOff == 3'd4) ? hWdata : '0;

  always_comb begin
    expRd    = '0;
    expKnown = 1'b1;
    if (hSel == 2'(`UC_SEL_CLINT)) begin
      case (hOff)
        3'd2:    expRd = shCmp[31:0];
        3'd3:    expRd = shCmp[63:32];
        3'd4:    expRd = shMsip;
        3'd0, 3'd1: expKnown = 1'b0;   // mtime runs freely
        default: expRd = '0;
      endcase
    end else if (hSel == 2'(`UC_SEL_GPIO)) begin
      case (hOff)
        3'd1:    expRd = shOut;
        3'd2:    expRd = shEn;
        3'd3:    expRd = shIe;
        3'd0, 3'd4: expKnown = 1'b0;   // pins and pending follow the inputs
        default: expRd = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reqValid) begin
      mWrite[wp] <= reqWrite;
      mAddr[wp]  <= reqAddr;
      mWdata[wp] <= reqWdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // shadow registers, updated as responses retire
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wp <= '0;
      rp <= '0;
      outstanding <= 0;
      shOut <= '0;
      shEn <= '0;
      shIe <= '0;
      shMsip <= '0;
      shCmp <= '1;
      armed <= '0;
      inPrev <= '0;
      lastMt <= '0;
      haveMt <= 1'b0;
      riseCnt <= 0;
      timerCnt <= 0;
    end else begin
      if (reqValid) wp <= wp + 3'd1;
      if (rspValid) rp <= rp + 3'd1;
      outstanding <= outstanding + int'(reqValid) - int'(rspValid);
      if (hGpio && hWrite) begin
        if (hOff == 3'd1) shOut <= hWdata;
        if (hOff == 3'd2) shEn  <= hWdata;
        if (hOff == 3'd3) shIe  <= hWdata;
      end
      if (hClint && hWrite) begin
        if (hOff == 3'd2) shCmp[31:0]  <= hWdata;
        if (hOff == 3'd3) shCmp[63:32] <= hWdata;
        if (hOff == 3'd4) shMsip       <= hWdata;
      end
      if (hClint && !hWrite && hOff == 3'd0) begin
        lastMt <= rspData;
        haveMt <= 1'b1;
      end
      inPrev <= gpioIn;
      armed  <= (armed & ~clr) | rise;
      // cycles since an enabled rise with no interrupt yet
      if (rise != '0) riseCnt <= 1;
      else if (gpioInt) riseCnt <= 0;
      else if (riseCnt != 0) riseCnt <= riseCnt + 1;
      // cycles since cmpLo was set with no timer interrupt yet
      if (hClint && hWrite && hOff == 3'd2) timerCnt <= 1;
      else if (timerInt) timerCnt <= 0;
      else if (timerCnt != 0) timerCnt <= timerCnt + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////

  resetZero: assert property (@(posedge clk) $rose(rstN) |->
      !rspValid && !creditReturn && !timerInt && !swInt && !gpioInt &&
      gpioOut == '0 && gpioEn == '0)
    else begin errCnt++; $error("outputs not zero after reset"); end

  creditMatch: assert property (@(posedge clk) disable iff (!rstN)
      creditReturn == rspValid)
    else begin errCnt++; $error("creditReturn differs from rspValid"); end

  creditLimit: assert property (@(posedge clk) disable iff (!rstN)
      outstanding <= `UC_CREDITS && (!rspValid || outstanding > 0))
    else begin
      errCnt++;
      $error("more requests in flight than credits, or a response with none in flight");
    end

  readData: assert property (@(posedge clk) disable iff (!rstN)
      rspValid && !hWrite && expKnown |-> rspData == expRd)
    else begin
      errCnt++;
      $error("FAILED readData addr %h exp %h act %h",
             $sampled(hAddr), $sampled(expRd), $sampled(rspData));
    end

  errFlag: assert property (@(posedge clk) disable iff (!rstN)
      rspValid |-> rspErr == hSel[1])
    else begin
      errCnt++;
      $error("FAILED errFlag exp %b act %b", $sampled(hSel[1]), $sampled(rspErr));
    end

  errNoEffect: assert property (@(posedge clk) disable iff (!rstN)
      rspValid && rspErr |-> rspData == '0 && gpioOut == shOut &&
      gpioEn == shEn && swInt == shMsip[0])
    else begin errCnt++; $error("unmapped access returned data or changed state"); end

  pinOut: assert property (@(posedge clk) disable iff (!rstN)
      hGpio && hWrite && hOff == 3'd1 |-> gpioOut == hWdata)
    else begin
      errCnt++;
      $error("FAILED pinOut exp %h act %h", $sampled(hWdata), $sampled(gpioOut));
    end

  pinEn: assert property (@(posedge clk) disable iff (!rstN)
      hGpio && hWrite && hOff == 3'd2 |-> gpioEn == hWdata)
    else begin
      errCnt++;
      $error("FAILED pinEn exp %h act %h", $sampled(hWdata), $sampled(gpioEn));
    end

  swIntMatch: assert property (@(posedge clk) disable iff (!rstN)
      hClint && hWrite && hOff == 3'd4 |-> swInt == hWdata[0])
    else begin
      errCnt++;
      $error("FAILED swInt exp %b act %b", $sampled(hWdata[0]), $sampled(swInt));
    end

  timerLow: assert property (@(posedge clk) disable iff (!rstN)
      hClint && hWrite && hOff == 3'd2 |-> !timerInt)
    else begin errCnt++; $error("timerInt already high when compare was set"); end

  timerLate: assert property (@(posedge clk) disable iff (!rstN) timerCnt <= 60)
    else begin errCnt++; $error("timerInt did not rise within 60 cycles"); end

  mtimeUp: assert property (@(posedge clk) disable iff (!rstN)
      hClint && !hWrite && hOff == 3'd0 && haveMt |-> rspData > lastMt)
    else begin
      errCnt++;
      $error("FAILED mtimeUp exp above %h act %h", $sampled(lastMt), $sampled(rspData));
    end

  gpioIntFast: assert property (@(posedge clk) disable iff (!rstN) riseCnt <= 4)
    else begin errCnt++; $error("gpioInt late after an enabled rise"); end

  gpioIntSpur: assert property (@(posedge clk) disable iff (!rstN)
      gpioInt |-> armed != '0)
    else begin errCnt++; $error("gpioInt high without an enabled rise"); end

  gpioIntClr: assert property (@(posedge clk) disable iff (!rstN)
      hGpio && hWrite && hOff == 3'd4 && (armed & ~hWdata) == '0 |-> !gpioInt)
    else begin errCnt++; $error("gpioInt still high after pending clear"); end

endmodule

// File: miniUncore.f
+incdir+verilog
verilog/uncorePkg.sv
verilog/periphBus.sv
verilog/busCtrl.sv
verilog/clint.sv
verilog/gpio.sv
verilog/uncoreTop.sv
dv/uncore_assert.sv
dv/clkGen.sv
dv/uncoreTb.sv

// File: verilog/busCtrl.sv
// bus controller
// queues credit-flow requests, decodes addr[7:6], strobes one peripheral
// and returns its read data in order with one credit per response

`include "uncore_defs.svh"

module busCtrl (
  input  logic            clk,
  input  logic            rstN,
  input  logic            reqValid,     // one cycle per request, master holds a credit
  input  logic            reqWrite,
  input  uncorePkg::addrT reqAddr,
  input  uncorePkg::dataT reqWdata,
  output logic            rspValid,
  output uncorePkg::dataT rspData,
  output logic            rspErr,
  output logic            creditReturn,
  periphBus.ctrl          clintBus,
  periphBus.ctrl          gpioBus
);

  localparam int ptrW = $clog2(`UC_CREDITS);
  localparam int cntW = $clog2(`UC_CREDITS + 1);

  ////////////////////////////////////////////////////////////
  // request queue
  ////////////////////////////////////////////////////////////

  logic                 qWrite [`UC_CREDITS];
  uncorePkg::addrT      qAddr  [`UC_CREDITS];
  uncorePkg::dataT      qWdata [`UC_CREDITS];
  logic [ptrW-1:0]      wrPtr, rdPtr;
  logic [cntW-1:0]      count;          // entries held
  logic                 full, push, pop;
  uncorePkg::ctrlStateT state, nextState;
  logic                 headWrite;
  uncorePkg::addrT      headAddr;
  uncorePkg::dataT      headWdata;
  logic [1:0]           headSel;        // block select bits of the head
  logic                 hitClint, hitGpio;
  logic                 respGpio;       // access in resp went to the gpio
  logic                 respErr;        // access in resp was unmapped

  assign full = (count == cntW'(`UC_CREDITS));
  assign pop  = (state == uncorePkg::CS_ISSUE);
  assign push = reqValid && (!full || pop); // a request without a credit is dropped

  // payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      qWrite[wrPtr] <= reqWrite;
      qAddr[wrPtr]  <= reqAddr;
      qWdata[wrPtr] <= reqWdata;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= (wrPtr == ptrW'(`UC_CREDITS - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)  rdPtr <= (rdPtr == ptrW'(`UC_CREDITS - 1)) ? '0 : rdPtr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;            // both or neither
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // decode and issue
  ////////////////////////////////////////////////////////////

  assign headWrite = qWrite[rdPtr];
  assign headAddr  = qAddr[rdPtr];
  assign headWdata = qWdata[rdPtr];
  assign headSel   = headAddr[`UC_ADDR_W-1 -: 2];
  assign hitClint  = (headSel == 2'(`UC_SEL_CLINT));
  assign hitGpio   = (headSel == 2'(`UC_SEL_GPIO));

  assign clintBus.sel   = pop && hitClint;
  assign clintBus.write = headWrite;
  assign clintBus.off   = headAddr[`UC_OFF_W-1:0];
  assign clintBus.wdata = headWdata;

  assign gpioBus.sel    = pop && hitGpio;
  assign gpioBus.write  = headWrite;
  assign gpioBus.off    = headAddr[`UC_OFF_W-1:0];
  assign gpioBus.wdata  = headWdata;

  // new work keeps the FSM cycling issue/resp, otherwise back to idle
  always_comb begin
    nextState = state;
    case (state)
      uncorePkg::CS_IDLE:  if (push || count != '0) nextState = uncorePkg::CS_ISSUE;
      uncorePkg::CS_ISSUE: nextState = uncorePkg::CS_RESP;
      uncorePkg::CS_RESP:  nextState = (push || count != '0) ? uncorePkg::CS_ISSUE
                                                             : uncorePkg::CS_IDLE;
      default:             nextState = uncorePkg::CS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state    <= uncorePkg::CS_IDLE;
      respGpio <= 1'b0;
      respErr  <= 1'b0;
    end else begin
      state <= nextState;
      if (pop) begin
        respGpio <= hitGpio;
        respErr  <= !(hitClint || hitGpio); // sel 2 or 3
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // response and credit
  ////////////////////////////////////////////////////////////

  assign rspValid     = (state == uncorePkg::CS_RESP);
  assign creditReturn = rspValid;             // one credit per response
  assign rspErr       = rspValid && respErr;
  assign rspData      = (rspValid && !respErr) ? (respGpio ? gpioBus.rdata : clintBus.rdata)
                                               : '0;

endmodule

// File: verilog/clint.sv
// CLINT-style timer block
// free running 64-bit mtime, mtimecmp compare and msip software interrupt

`include "uncore_defs.svh"

module clint (
  input  logic     clk,
  input  logic     rstN,
  periphBus.periph bus,
  output logic     timerInt,   // mtime >= mtimecmp, registered
  output logic     swInt       // msip bit 0
);

  localparam uncorePkg::offT offMtimeLo = uncorePkg::offT'(0);
  localparam uncorePkg::offT offMtimeHi = uncorePkg::offT'(1);
  localparam uncorePkg::offT offCmpLo   = uncorePkg::offT'(2);
  localparam uncorePkg::offT offCmpHi   = uncorePkg::offT'(3);
  localparam uncorePkg::offT offMsip    = uncorePkg::offT'(4);

  uncorePkg::mtimeT mtime;
  uncorePkg::mtimeT mtimecmp;
  uncorePkg::dataT  msip;
  uncorePkg::dataT  readVal;
  logic             wrEn;

  assign wrEn = bus.sel && bus.write;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  // a half write replaces that half, the count skips that cycle
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mtime <= '0;
    end else if (wrEn && bus.off == offMtimeLo) begin
      mtime <= {mtime[63:`UC_DATA_W], bus.wdata};
    end else if (wrEn && bus.off == offMtimeHi) begin
      mtime <= {bus.wdata, mtime[`UC_DATA_W-1:0]};
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mtimecmp <= '1;                       // far future, no timer irq
      msip     <= '0;
      timerInt <= 1'b0;
    end else begin
      if (wrEn && bus.off == offCmpLo) mtimecmp[`UC_DATA_W-1:0] <= bus.wdata;
      if (wrEn && bus.off == offCmpHi) mtimecmp[63:`UC_DATA_W]  <= bus.wdata;
      if (wrEn && bus.off == offMsip)  msip <= bus.wdata;
      timerInt <= (mtime >= mtimecmp);
    end
  end

  assign swInt = msip[0];

  ////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (bus.off)
      offMtimeLo: readVal = mtime[`UC_DATA_W-1:0];
      offMtimeHi: readVal = mtime[63:`UC_DATA_W];
      offCmpLo:   readVal = mtimecmp[`UC_DATA_W-1:0];
      offCmpHi:   readVal = mtimecmp[63:`UC_DATA_W];
      offMsip:    readVal = msip;
      default:    readVal = '0;         // unused offsets
    endcase
  end

  // value before this edge's update
  always_ff @(posedge clk) begin
    if (bus.sel) bus.rdata <= readVal;
  end

endmodule

// File: verilog/gpio.sv
// GPIO block
// output and enable registers, synchronized inputs and a rising-edge
// interrupt with per-bit enable and write-1-to-clear pending bits

module gpio (
  input  logic            clk,
  input  logic            rstN,
  input  uncorePkg::dataT gpioIn,     // asynchronous pins
  periphBus.periph        bus,
  output uncorePkg::dataT gpioOut,
  output uncorePkg::dataT gpioEn,
  output logic            gpioInt     // any pending rise
);

  localparam uncorePkg::offT offIn       = uncorePkg::offT'(0);
  localparam uncorePkg::offT offOut      = uncorePkg::offT'(1);
  localparam uncorePkg::offT offEn       = uncorePkg::offT'(2);
  localparam uncorePkg::offT offRiseIe   = uncorePkg::offT'(3);
  localparam uncorePkg::offT offRisePend = uncorePkg::offT'(4);

  uncorePkg::dataT inMeta, inSync, inPrev; // two-flop sync plus edge history
  uncorePkg::dataT riseIe, risePend;
  uncorePkg::dataT rise, pendClr;
  uncorePkg::dataT readVal;
  logic            wrEn;

  assign wrEn = bus.sel && bus.write;

  ////////////////////////////////////////////////////////////
  // input sync and edge detect
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      inMeta <= '0;
      inSync <= '0;
      inPrev <= '0;
    end else begin
      inMeta <= gpioIn;
      inSync <= inMeta;
      inPrev <= inSync;
    end
  end

  assign rise    = inSync & ~inPrev & riseIe;           // only enabled bits
  assign pendClr = (wrEn && bus.off == offRisePend) ? bus.wdata : '0;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      gpioOut  <= '0;
      gpioEn   <= '0;
      riseIe   <= '0;
      risePend <= '0;
    end else begin
      if (wrEn && bus.off == offOut)    gpioOut <= bus.wdata;
      if (wrEn && bus.off == offEn)     gpioEn  <= bus.wdata;
      if (wrEn && bus.off == offRiseIe) riseIe  <= bus.wdata;
      risePend <= (risePend & ~pendClr) | rise;        // new edge beats clear
    end
  end

  assign gpioInt = |risePend;

  // read mux, offset 0 is read only
  always_comb begin
    case (bus.off)
      offIn:       readVal = inSync;
      offOut:      readVal = gpioOut;
      offEn:       readVal = gpioEn;
      offRiseIe:   readVal = riseIe;
      offRisePend: readVal = risePend;
      default:     readVal = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (bus.sel) bus.rdata <= readVal;
  end

endmodule

// File: verilog/periphBus.sv
// controller to peripheral register bus
// sel is a one cycle strobe; writes land on that edge and rdata is
// registered on the same edge, so it is valid the cycle after

interface periphBus;

  logic            sel;    // access strobe, one cycle
  logic            write;  // 1 write, 0 read
  uncorePkg::offT  off;    // register offset
  uncorePkg::dataT wdata;  // write data
  uncorePkg::dataT rdata;  // registered read data from the peripheral

  // controller side
  modport ctrl (
    output sel,
    output write,
    output off,
    output wdata,
    input  rdata
  );

  // peripheral side
  modport periph (
    input  sel,
    input  write,
    input  off,
    input  wdata,
    output rdata
  );

endinterface

// File: verilog/uncorePkg.sv
// miniUncore package
// vector types with a meaning and the bus controller state encoding

`include "uncore_defs.svh"

package uncorePkg;

  ////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////

  typedef logic [`UC_DATA_W-1:0] dataT;  // bus data
  typedef logic [`UC_ADDR_W-1:0] addrT;  // word address, bits 7:6 pick the block
  typedef logic [`UC_OFF_W-1:0]  offT;   // register offset
  typedef logic [63:0]           mtimeT; // clint timer and compare

  ////////////////////////////////////////////////////////////
  // controller FSM
  ////////////////////////////////////////////////////////////

  // one access in flight at a time
  //   idle  -> nothing queued
  //   issue -> sel pulse to the decoded peripheral, head popped
  //   resp  -> response and credit back to the master
  typedef enum logic [1:0] {
    CS_IDLE  = 2'd0,
    CS_ISSUE = 2'd1,
    CS_RESP  = 2'd2
  } ctrlStateT;

endpackage

// File: verilog/uncoreTop.sv
// miniUncore top level
// credit-flow request port into the bus controller, which drives the
// CLINT timer and the GPIO block over two register buses

module uncoreTop (
  input  logic            clk,
  input  logic            rstN,         // asynchronous, active low
  // request port, master side drives
  input  logic            reqValid,
  input  logic            reqWrite,
  input  uncorePkg::addrT reqAddr,
  input  uncorePkg::dataT reqWdata,
  // response port
  output logic            rspValid,
  output uncorePkg::dataT rspData,
  output logic            rspErr,
  output logic            creditReturn, // high with every rspValid
  // interrupts
  output logic            timerInt,
  output logic            swInt,
  output logic            gpioInt,
  // gpio pins
  input  uncorePkg::dataT gpioIn,
  output uncorePkg::dataT gpioOut,
  output uncorePkg::dataT gpioEn
);

  ////////////////////////////////////////////////////////////
  // register buses, one per peripheral
  ////////////////////////////////////////////////////////////

  periphBus clintBus();
  periphBus gpioBus();

  ////////////////////////////////////////////////////////////
  // controller and peripherals
  ////////////////////////////////////////////////////////////

  busCtrl busCtrl (
    .clk, .rstN,
    .reqValid, .reqWrite, .reqAddr, .reqWdata,
    .rspValid, .rspData, .rspErr, .creditReturn,
    .clintBus, .gpioBus
  );

  // timer, addr[7:6] == 0
  clint clint (
    .clk, .rstN,
    .bus(clintBus),
    .timerInt, .swInt
  );

  // gpio, addr[7:6] == 1
  gpio gpio (
    .clk, .rstN,
    .gpioIn,
    .bus(gpioBus),
    .gpioOut, .gpioEn, .gpioInt
  );

endmodule

// File: verilog/uncore_defs.svh
// miniUncore shared parameters
// data and address widths, credit count and the peripheral address map

`ifndef UNCORE_DEFS_SVH
`define UNCORE_DEFS_SVH

////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////

`define UC_DATA_W 32   // bus data
`define UC_ADDR_W 8    // word address
`define UC_OFF_W  3    // register offset inside a peripheral

// request credits held by the master, also the queue depth
`define UC_CREDITS 4

////////////////////////////////////////////////////////////
// address map on addr[7:6]
////////////////////////////////////////////////////////////

`define UC_SEL_CLINT 0  // timer block
`define UC_SEL_GPIO  1  // gpio block
// 2 and 3 unmapped, answered with an error

`endif
